/* Makefile */
TOP = xt_peripherals_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f vlog.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/bus_read_mux.sv */
/*
 * Registered CPU read-back. Result appears one cycle after the sampled cycle.
 * Interrupt acknowledge wins over every select and ignores the address.
 */
`timescale 1ns/10ps

module bus_read_mux
    import xt_periph_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  io_bus_t    bus_i,
    input  logic       int_ack_n_i,
    input  port_sel_t  sel_i,
    input  logic [7:0] pic_data_i,
    input  logic [7:0] pit_data_i,
    input  logic [7:0] ppi_data_i,
    input  logic [7:0] ems_data_i,
    input  logic [7:0] lpt_data_i,
    input  logic [7:0] nmi_data_i,
    output logic [7:0] read_data_o,
    output logic       data_valid_o
);

    logic       io_read;
    logic [7:0] data_d;
    logic       valid_d;

    assign io_read = ~bus_i.io_read_n;

    always_comb begin
        valid_d = 1'b1;
        data_d  = 8'h00;
        if (~int_ack_n_i) begin
            // Vector byte from the PIC
            data_d = pic_data_i;
        end else if (~sel_i.pic_n && io_read) begin
            data_d = pic_data_i;
        end else if (~sel_i.pit_n && io_read) begin
            data_d = pit_data_i;
        end else if (~sel_i.ppi_n && io_read) begin
            data_d = ppi_data_i;
        end else if (sel_i.ems && io_read) begin
            data_d = ems_data_i;
        end else if (sel_i.lpt && io_read) begin
            data_d = lpt_data_i;
        end else if (sel_i.nmi && io_read) begin
            data_d = nmi_data_i;
        end else begin
            valid_d = 1'b0;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_data_o  <= 8'h00;
            data_valid_o <= 1'b0;
        end else begin
            read_data_o  <= data_d;
            data_valid_o <= valid_d;
        end
    end

endmodule

/* hw/ems_page_mapper.sv */
/*
 * Four-slot EMS page map. A write lands one cycle after the bus write,
 * so the new mapping is readable two cycles after it.
 * Data FFh unmaps a slot; 80h..FEh are ignored.
 */
`timescale 1ns/10ps
`include "xt_periph_defines.svh"

module ems_page_mapper
    import xt_periph_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  io_bus_t                  bus_i,
    input  logic                     ems_sel_i,
    input  logic [1:0]               ems_frame_i,
    output logic [`XT_EMS_SLOTS-1:0] ems_hit_o,
    output logic [7:0]               ems_read_o
);

    ems_slot_t  slot_q [`XT_EMS_SLOTS];

    logic       wr_pending_q;
    logic [1:0] wr_slot_q;
    logic [7:0] wr_data_q;

    logic       memory_cycle;
    logic [3:0] frame_base;
    ems_slot_t  read_slot;

    // Capture stage
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_pending_q <= 1'b0;
        end else begin
            wr_pending_q <= ems_sel_i & ~bus_i.io_write_n;
        end
    end

    always_ff @(posedge clock) begin
        wr_slot_q <= bus_i.address[1:0];
        wr_data_q <= bus_i.write_data;
    end

    // Update stage
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            slot_q <= '{default: '0};
        end else if (wr_pending_q) begin
            if (wr_data_q == 8'hff) begin
                slot_q[wr_slot_q].enable <= 1'b0;
            end else if (~wr_data_q[7]) begin
                slot_q[wr_slot_q].enable <= 1'b1;
                slot_q[wr_slot_q].page   <= wr_data_q[6:0];
            end
        end
    end

    // Read-back for the addressed slot
    assign read_slot  = slot_q[bus_i.address[1:0]];
    assign ems_read_o = read_slot.enable ? {1'b0, read_slot.page} : `XT_REG_RESET_VALUE;

    // Window hits, memory cycles only
    assign memory_cycle = bus_i.io_read_n & bus_i.io_write_n
        & (~bus_i.memory_read_n | ~bus_i.memory_write_n);

    always_comb begin
        case (ems_frame_i)
            2'd0:    frame_base = `XT_EMS_PAGE_A;
            2'd1:    frame_base = `XT_EMS_PAGE_C;
            default: frame_base = `XT_EMS_PAGE_D;
        endcase
    end

    // Each slot covers one 16 KB window inside the 64 KB frame
    always_comb begin
        for (int k = 0; k < `XT_EMS_SLOTS; k++) begin
            ems_hit_o[k] = memory_cycle & slot_q[k].enable
                & (bus_i.address[19:14] == {frame_base, 2'(k)});
        end
    end

endmodule

/* hw/io_port_decoder.sv */
/*
 * Combinational I/O address decode, zero cycles of latency.
 * Only address bits 15:0 take part; bits 19:16 are ignored for I/O.
 */
`timescale 1ns/10ps
`include "xt_periph_defines.svh"

module io_port_decoder
    import xt_periph_pkg::*;
(
    input  io_bus_t   bus_i,
    input  logic      ems_enabled_i,
    input  logic      tandy_mode_i,
    output port_sel_t sel_o
);

    logic        io_cycle;
    logic        intel_space;
    logic [15:0] block_base;

    // Any I/O strobe with the CPU owning the bus
    assign io_cycle = (~bus_i.io_read_n | ~bus_i.io_write_n) & ~bus_i.address_enable_n;

    // Intel chips live in the 32-port blocks below 100h
    assign intel_space = io_cycle & ~bus_i.address[9] & ~bus_i.address[8];
    assign block_base  = {8'h00, bus_i.address[7:5], 5'h00};

    always_comb begin
        sel_o.dma_n      = ~(intel_space & (block_base == `XT_DMA_BASE));
        sel_o.pic_n      = ~(intel_space & (block_base == `XT_PIC_BASE));
        sel_o.pit_n      = ~(intel_space & (block_base == `XT_PIT_BASE));
        sel_o.ppi_n      = ~(intel_space & (block_base == `XT_PPI_BASE));
        sel_o.dma_page_n = ~(intel_space & (block_base == `XT_DMA_PAGE_BASE));

        // 260h..263h, one port per map slot
        sel_o.ems = io_cycle & ems_enabled_i
            & ({bus_i.address[15:2], 2'b00} == `XT_EMS_PORT_BASE);

        sel_o.lpt = io_cycle & (bus_i.address[15:0] == `XT_LPT_PORT);

        // A0h..A7h, Tandy machines only
        sel_o.nmi = io_cycle & tandy_mode_i
            & ({bus_i.address[15:3], 3'b000} == `XT_NMI_PORT_BASE);
    end

endmodule

/* hw/lpt_nmi_registers.sv */
/*
 * Parallel-port data latch and NMI mask register, both reset to FFh.
 * A write is visible on the outputs from the next cycle on.
 */
`timescale 1ns/10ps
`include "xt_periph_defines.svh"

module lpt_nmi_registers
    import xt_periph_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  io_bus_t    bus_i,
    input  logic       lpt_sel_i,
    input  logic       nmi_sel_i,
    output logic [7:0] lpt_o,
    output logic [7:0] nmi_mask_o
);

    logic write_strobe;

    // Every cycle with the write strobe low counts as one write
    assign write_strobe = ~bus_i.io_write_n;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_o <= `XT_REG_RESET_VALUE;
        end else if (lpt_sel_i && write_strobe) begin
            lpt_o <= bus_i.write_data;
        end
    end

    // Bit 7 gates NMI on the Tandy
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_mask_o <= `XT_REG_RESET_VALUE;
        end else if (nmi_sel_i && write_strobe) begin
            nmi_mask_o <= bus_i.write_data;
        end
    end

endmodule

/* hw/xt_periph_defines.svh */
/*
 * Port addresses, EMS page-frame bases and register reset values.
 * The Intel-chip bases must stay below 100h and on 32-port boundaries.
 */
`ifndef XT_PERIPH_DEFINES_SVH
`define XT_PERIPH_DEFINES_SVH

// 32-port blocks decoded below 100h
`define XT_DMA_BASE        16'h0000
`define XT_PIC_BASE        16'h0020
`define XT_PIT_BASE        16'h0040
`define XT_PPI_BASE        16'h0060
`define XT_DMA_PAGE_BASE   16'h0080

// Fixed ports
`define XT_EMS_PORT_BASE   16'h0260
`define XT_LPT_PORT        16'h0378
`define XT_NMI_PORT_BASE   16'h00a0

// Page-frame bases, address bits 19:16
`define XT_EMS_PAGE_A      4'ha
`define XT_EMS_PAGE_C      4'hc
`define XT_EMS_PAGE_D      4'hd

`define XT_EMS_SLOTS       4

// Also read back for an unmapped EMS slot
`define XT_REG_RESET_VALUE 8'hff

`endif

/* hw/xt_periph_pkg.sv */
/*
 * Bus, chip-select and EMS slot types shared by the peripheral glue.
 * Selects for the external Intel chips are active low, the rest active high.
 */
package xt_periph_pkg;

    // CPU-side bus as seen by the glue logic
    typedef struct packed {
        logic [19:0] address;
        logic [7:0]  write_data;
        logic        io_read_n;
        logic        io_write_n;
        logic        memory_read_n;
        logic        memory_write_n;
        logic        address_enable_n;
    } io_bus_t;

    typedef struct packed {
        // External chips
        logic dma_n;
        logic pic_n;
        logic pit_n;
        logic ppi_n;
        logic dma_page_n;
        // Registers held in this block
        logic ems;
        logic lpt;
        logic nmi;
    } port_sel_t;

    // One EMS map slot
    typedef struct packed {
        logic       enable;
        logic [6:0] page;
    } ems_slot_t;

endpackage

/* hw/xt_peripherals.sv */
/*
 * XT peripheral glue: I/O decode, EMS page map, LPT/NMI latches, read-back.
 * The PIC, PIT and PPI are external and only get selects and read paths.
 */
`timescale 1ns/10ps

module xt_peripherals
    import xt_periph_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  io_bus_t    bus_i,
    input  logic       int_ack_n_i,
    input  logic       ems_enabled_i,
    input  logic [1:0] ems_frame_i,
    input  logic       tandy_mode_i,
    input  logic [7:0] pic_data_i,
    input  logic [7:0] pit_data_i,
    input  logic [7:0] ppi_data_i,
    output port_sel_t  sel_o,
    output logic [3:0] ems_hit_o,
    output logic [7:0] read_data_o,
    output logic       data_valid_o
);

    logic [7:0] ems_read;
    logic [7:0] lpt_data;
    logic [7:0] nmi_mask;

    io_port_decoder u_io_port_decoder (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .tandy_mode_i  (tandy_mode_i),
        .sel_o         (sel_o)
    );

    ems_page_mapper u_ems_page_mapper (
        .clock       (clock),
        .reset       (reset),
        .bus_i       (bus_i),
        .ems_sel_i   (sel_o.ems),
        .ems_frame_i (ems_frame_i),
        .ems_hit_o   (ems_hit_o),
        .ems_read_o  (ems_read)
    );

    lpt_nmi_registers u_lpt_nmi_registers (
        .clock      (clock),
        .reset      (reset),
        .bus_i      (bus_i),
        .lpt_sel_i  (sel_o.lpt),
        .nmi_sel_i  (sel_o.nmi),
        .lpt_o      (lpt_data),
        .nmi_mask_o (nmi_mask)
    );

    bus_read_mux u_bus_read_mux (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .int_ack_n_i  (int_ack_n_i),
        .sel_i        (sel_o),
        .pic_data_i   (pic_data_i),
        .pit_data_i   (pit_data_i),
        .ppi_data_i   (ppi_data_i),
        .ems_data_i   (ems_read),
        .lpt_data_i   (lpt_data),
        .nmi_data_i   (nmi_mask),
        .read_data_o  (read_data_o),
        .data_valid_o (data_valid_o)
    );

endmodule

/* verif/xt_peripherals_checker.sv */
/*
 * Bus-level invariants of the peripheral glue, bound to the top level.
 * Checks are disabled while reset is high.
 */
`timescale 1ns/10ps

module xt_peripherals_checker
    import xt_periph_pkg::*;
(
    input logic       clock,
    input logic       reset,
    input io_bus_t    bus_i,
    input port_sel_t  sel_i,
    input logic [3:0] ems_hit_i,
    input logic [7:0] read_data_i,
    input logic       data_valid_i
);

    logic [4:0] intel_selects;
    logic       io_cycle;
    // Failed assertions so far
    int         failure_count = 0;

    assign intel_selects = ~{sel_i.dma_n, sel_i.pic_n, sel_i.pit_n, sel_i.ppi_n, sel_i.dma_page_n};
    assign io_cycle = (~bus_i.io_read_n | ~bus_i.io_write_n) & ~bus_i.address_enable_n;

    intel_select_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(intel_selects))
        else begin
            failure_count++;
            $error("more than one Intel chip select is active");
        end

    idle_data_zero: assert property (@(posedge clock) disable iff (reset)
        !data_valid_i |-> read_data_i == 8'h00)
        else begin
            failure_count++;
            $error("read data is not zero while data_valid is low");
        end

    no_hit_on_io: assert property (@(posedge clock) disable iff (reset)
        io_cycle |-> ems_hit_i == 4'h0)
        else begin
            failure_count++;
            $error("EMS window hit during an I/O cycle");
        end

endmodule

/* verif/xt_peripherals_tb.sv */
/*
 * Directed testbench for the XT peripheral glue. Every bus operation takes
 * two clocks: the cycle itself, then an idle cycle that shows the read result.
 */
`timescale 1ns/10ps
`include "xt_periph_defines.svh"

module xt_peripherals_tb
    import xt_periph_pkg::*;
();

    localparam int CLOCK_PERIOD = 4;
    localparam int NUM_OPS      = 64;
    localparam int IDLE         = 0;
    localparam int IO_READ      = 1;
    localparam int IO_WRITE     = 2;
    localparam int MEM_READ     = 3;
    // All active-low selects high, active-high ones low
    localparam port_sel_t NO_SEL = 8'b11111_000;

    logic       clock;
    logic       reset;
    io_bus_t    bus;
    logic       int_ack_n;
    logic       ems_enabled;
    logic [1:0] ems_frame;
    logic       tandy_mode;
    logic [7:0] pic_data;
    logic [7:0] pit_data;
    logic [7:0] ppi_data;
    port_sel_t  sel;
    logic [3:0] ems_hit;
    logic [7:0] read_data;
    logic       data_valid;

    // Captured by the last bus operation
    port_sel_t  sel_seen;
    logic [3:0] hits_seen;
    logic [7:0] data_seen;
    logic       valid_seen;

    xt_peripherals dut (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus),
        .int_ack_n_i  (int_ack_n),
        .ems_enabled_i(ems_enabled),
        .ems_frame_i  (ems_frame),
        .tandy_mode_i (tandy_mode),
        .pic_data_i   (pic_data),
        .pit_data_i   (pit_data),
        .ppi_data_i   (ppi_data),
        .sel_o        (sel),
        .ems_hit_o    (ems_hit),
        .read_data_o  (read_data),
        .data_valid_o (data_valid)
    );

    bind xt_peripherals xt_peripherals_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .sel_i        (sel_o),
        .ems_hit_i    (ems_hit_o),
        .read_data_i  (read_data_o),
        .data_valid_i (data_valid_o)
    );

    initial clock = 1'b0;
    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic io_bus_t make_bus(input logic [19:0] address, input logic [7:0] data,
                                         input int kind);
        io_bus_t b;
        b.address          = address;
        b.write_data       = data;
        b.io_read_n        = (kind != IO_READ);
        b.io_write_n       = (kind != IO_WRITE);
        b.memory_read_n    = (kind != MEM_READ);
        b.memory_write_n   = 1'b1;
        b.address_enable_n = 1'b0;
        return b;
    endfunction

    // Selects and hits seen mid-cycle, read result one cycle later
    task automatic bus_cycle(input io_bus_t b, input logic ack_n);
        @(posedge clock);
        bus       <= b;
        int_ack_n <= ack_n;
        @(negedge clock);
        sel_seen  = sel;
        hits_seen = ems_hit;
        @(posedge clock);
        bus       <= make_bus(20'h0, 8'h00, IDLE);
        int_ack_n <= 1'b1;
        @(negedge clock);
        data_seen  = read_data;
        valid_seen = data_valid;
    endtask

    task automatic io_read(input logic [19:0] address);
        bus_cycle(make_bus(address, 8'h00, IO_READ), 1'b1);
    endtask

    task automatic io_write(input logic [19:0] address, input logic [7:0] data);
        bus_cycle(make_bus(address, data, IO_WRITE), 1'b1);
    endtask

    task automatic mem_read(input logic [19:0] address);
        bus_cycle(make_bus(address, 8'h00, MEM_READ), 1'b1);
    endtask

    task automatic check_sel(input port_sel_t got, input port_sel_t expected, input string what);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s select %b, expected %b", $time, what, got, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic got_valid,
                              input logic [7:0] expected, input logic expected_valid,
                              input string what);
        if (got !== expected || got_valid !== expected_valid) begin
            $display("mismatch at %0t ns: %s read %h valid %b, expected %h valid %b",
                     $time, what, got, got_valid, expected, expected_valid);
            $display("Testbench failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_hits(input logic [3:0] got, input logic [3:0] expected,
                              input string what);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s hits %b, expected %b", $time, what, got, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic test_reset_values();
        @(negedge clock);
        check_byte(read_data, data_valid, 8'h00, 1'b0, "after reset");
        io_read(20'h00378);
        check_byte(data_seen, valid_seen, `XT_REG_RESET_VALUE, 1'b1, "LPT reset");
        io_read(20'h000a0);
        check_byte(data_seen, valid_seen, `XT_REG_RESET_VALUE, 1'b1, "NMI reset");
        for (int s = 0; s < 4; s++) begin
            io_read(20'h00260 + 20'(s));
            check_byte(data_seen, valid_seen, 8'hff, 1'b1, "EMS slot reset");
            mem_read({`XT_EMS_PAGE_A, 2'(s), 14'h0123});
            check_hits(hits_seen, 4'h0, "EMS window after reset");
        end
    endtask

    task automatic test_decode();
        for (int k = 0; k < 5; k++) begin
            io_read({12'h000, 3'(k), 5'($urandom)});
            check_sel(sel_seen, port_sel_t'(NO_SEL & ~(8'h80 >> k)), "Intel block");
            // DMA and page chips have no read path here
            if (k == 0 || k == 4) begin
                check_byte(data_seen, valid_seen, 8'h00, 1'b0, "unmapped read");
            end
        end
        @(posedge clock);
        ems_enabled <= 1'b0;
        tandy_mode  <= 1'b0;
        io_read(20'h00260);
        check_sel(sel_seen, NO_SEL, "EMS disabled");
        io_read(20'h000a0);
        check_sel(sel_seen, NO_SEL, "NMI outside Tandy mode");
        @(posedge clock);
        ems_enabled <= 1'b1;
        tandy_mode  <= 1'b1;
        io_read(20'h00262);
        check_sel(sel_seen, port_sel_t'(NO_SEL | 8'h04), "EMS port");
        io_read(20'h000a7);
        check_sel(sel_seen, port_sel_t'(NO_SEL | 8'h01), "NMI port");
        io_read(20'h00378);
        check_sel(sel_seen, port_sel_t'(NO_SEL | 8'h02), "LPT port");
        mem_read(20'h00040);
        check_sel(sel_seen, NO_SEL, "memory cycle");
    endtask

    task automatic test_external_reads();
        @(posedge clock);
        pic_data <= 8'($urandom);
        pit_data <= 8'($urandom);
        ppi_data <= 8'($urandom);
        io_read(20'h00021);
        check_byte(data_seen, valid_seen, pic_data, 1'b1, "PIC read");
        io_read(20'h00043);
        check_byte(data_seen, valid_seen, pit_data, 1'b1, "PIT read");
        io_read(20'h00061);
        check_byte(data_seen, valid_seen, ppi_data, 1'b1, "PPI read");
        // Acknowledge ignores the address entirely
        bus_cycle(make_bus(20'($urandom), 8'h00, IDLE), 1'b0);
        check_byte(data_seen, valid_seen, pic_data, 1'b1, "interrupt acknowledge");
    endtask

    task automatic test_lpt_nmi();
        logic [7:0] value;
        value = 8'($urandom);
        io_write(20'h00378, value);
        io_read(20'h00378);
        check_byte(data_seen, valid_seen, value, 1'b1, "LPT write");
        value = 8'($urandom);
        io_write(20'h000a5, value);
        io_read(20'h000a2);
        check_byte(data_seen, valid_seen, value, 1'b1, "NMI write");
    endtask

    task automatic test_ems_map();
        logic [6:0] page;
        page = 7'($urandom);
        io_write(20'h00261, {1'b0, page});
        io_read(20'h00261);
        check_byte(data_seen, valid_seen, {1'b0, page}, 1'b1, "EMS map");
        // 80h..FEh must leave the mapping alone
        io_write(20'h00261, 8'h80 + 8'($urandom % 127));
        io_read(20'h00261);
        check_byte(data_seen, valid_seen, {1'b0, page}, 1'b1, "EMS ignored write");
        io_write(20'h00261, 8'hff);
        io_read(20'h00261);
        check_byte(data_seen, valid_seen, 8'hff, 1'b1, "EMS unmap");
        io_write(20'h00261, 8'h9a);
        io_read(20'h00261);
        check_byte(data_seen, valid_seen, 8'hff, 1'b1, "EMS ignored on unmapped");
    endtask

    task automatic test_ems_windows();
        logic [3:0] base;
        for (int s = 0; s < 3; s++) begin
            io_write(20'h00260 + 20'(s), 8'($urandom % 128));
        end
        io_write(20'h00263, 8'hff);
        for (int f = 0; f < 4; f++) begin
            @(posedge clock);
            ems_frame <= 2'(f);
            base = (f == 0) ? `XT_EMS_PAGE_A : (f == 1) ? `XT_EMS_PAGE_C : `XT_EMS_PAGE_D;
            for (int k = 0; k < 4; k++) begin
                mem_read({base, 2'(k), 14'($urandom)});
                check_hits(hits_seen, (k < 3) ? 4'(1 << k) : 4'h0, "EMS window");
            end
        end
    endtask

    initial begin
        void'($urandom(32'hcb97_afee));
        reset       <= 1'b1;
        bus         <= make_bus(20'h0, 8'h00, IDLE);
        int_ack_n   <= 1'b1;
        ems_enabled <= 1'b1;
        ems_frame   <= 2'd0;
        tandy_mode  <= 1'b1;
        pic_data    <= 8'h00;
        pit_data    <= 8'h00;
        ppi_data    <= 8'h00;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        test_reset_values();
        test_decode();
        test_external_reads();
        test_lpt_nmi();
        test_ems_map();
        test_ems_windows();
        $display("Testbench passed");
        $finish;
    end

    // Generous bound of 40 clocks per bus operation
    initial begin
        #(NUM_OPS * 40 * CLOCK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    initial begin
        wait (dut.u_checker.failure_count != 0);
        $display("A bus invariant assertion in the checker failed");
        $display("Testbench failed");
        $fatal(1, "assertion failure");
    end

endmodule

/* vlog.f */
+incdir+hw
hw/xt_periph_pkg.sv
hw/io_port_decoder.sv
hw/ems_page_mapper.sv
hw/lpt_nmi_registers.sv
hw/bus_read_mux.sv
hw/xt_peripherals.sv
verif/xt_peripherals_checker.sv
verif/xt_peripherals_tb.sv
